//--- logic/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// player and button counts
`define BOARD_PLAYERS 4
`define BOARD_BUTTONS 2

// joystick widths
`define JOY_IN_W  16
`define JOY_OUT_W 10
`define JOY_DIR_W 4

// button positions in the board joystick word
// these move up with each extra game button
`define START_BIT (6 + `BOARD_BUTTONS - 2)
`define COIN_BIT  (7 + `BOARD_BUTTONS - 2)
`define PAUSE_BIT (8 + `BOARD_BUTTONS - 2)

// graphics layers with a debug enable key
`define GFX_LAYERS 4

`endif

//--- logic/board_input_pkg.sv
`include "board_macros.svh"

package board_input_pkg;

    // raw word from the board joystick
    typedef logic [`JOY_IN_W-1:0] board_joy_t;

    // conditioned word seen by the game
    typedef logic [`JOY_OUT_W-1:0] game_joy_t;

    // bit 0 up, 1 down, 2 left, 3 right
    typedef logic [`JOY_DIR_W-1:0] joy_dir_t;

    // direction remap for vertical games
    typedef enum logic [1:0] {
        ROT_NONE = 2'd0,
        ROT_CW   = 2'd1,
        ROT_CCW  = 2'd2
    } rot_mode_e;

    typedef enum logic {
        PAUSE_RUN  = 1'b0,
        PAUSE_HELD = 1'b1
    } pause_state_e;

endpackage

//--- logic/input_evt_if.sv
`timescale 1ns/1ps
`include "board_macros.svh"

interface input_evt_if;

    // button levels from the sync stages
    // each player path drives its own bit, hence nets
    wire [`BOARD_PLAYERS-1:0] coin_btn;
    wire [`BOARD_PLAYERS-1:0] start_btn;
    wire [`BOARD_PLAYERS-1:0] pause_btn;

    // one cycle pulse from the key controller
    logic key_pause_rise;

    modport player_src (
        output coin_btn,
        output start_btn,
        output pause_btn
    );

    modport key_src (output key_pause_rise);

    modport merge_dst (
        input coin_btn,
        input start_btn,
        input pause_btn,
        input key_pause_rise
    );

endinterface

//--- logic/joy_player_path.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module joy_player_path
    import board_input_pkg::*;
#(
    parameter int player_idx             = 0,
    parameter bit game_inputs_active_low = 1'b1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  board_joy_t             board_joy,
    input  game_joy_t              key_joy,
    input  logic                   en4way,
    input  logic                   rot_control,
    input  logic                   flip,
    input_evt_if.player_src        evt,
    output game_joy_t              game_joy
);

    localparam game_joy_t invert_mask = {`JOY_OUT_W{game_inputs_active_low}};

    joy_dir_t   dir_raw;
    joy_dir_t   dir_mem;
    joy_dir_t   dir_4way;
    board_joy_t joy_sync;
    game_joy_t  joy_merged;
    game_joy_t  joy_rot;
    rot_mode_e  rot_mode;

    assign dir_raw = board_joy[`JOY_DIR_W-1:0];

    // 4-way filter: a single direction wins and is kept while still held
    always_comb begin
        dir_4way = dir_raw;
        if (en4way) begin
            if ($onehot(dir_raw)) begin
                dir_4way = dir_raw;
            end else if ((dir_raw & dir_mem) != '0) begin
                dir_4way = dir_mem;
            end else begin
                dir_4way = '0;
            end
        end
    end

    // memory follows the filter output, so it clears when nothing passes
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_mem <= '0;
        end else if (en4way) begin
            dir_mem <= dir_4way;
        end
    end

    // sync stage
    always_ff @(posedge clk_sys) begin
        joy_sync <= {board_joy[`JOY_IN_W-1:`JOY_DIR_W], dir_4way};
    end

    assign evt.coin_btn[player_idx]  = joy_sync[`COIN_BIT];
    assign evt.start_btn[player_idx] = joy_sync[`START_BIT];
    assign evt.pause_btn[player_idx] = joy_sync[`PAUSE_BIT];

    always_comb begin
        if (!rot_control) begin
            rot_mode = ROT_NONE;
        end else if (flip) begin
            rot_mode = ROT_CW;
        end else begin
            rot_mode = ROT_CCW;
        end
    end

    assign joy_merged = joy_sync[`JOY_OUT_W-1:0] | key_joy;

    // only the direction nibble moves, buttons stay put
    always_comb begin
        case (rot_mode)
            ROT_CW: begin
                joy_rot = {joy_merged[`JOY_OUT_W-1:4],
                           joy_merged[1], joy_merged[0], joy_merged[2], joy_merged[3]};
            end
            ROT_CCW: begin
                joy_rot = {joy_merged[`JOY_OUT_W-1:4],
                           joy_merged[0], joy_merged[1], joy_merged[3], joy_merged[2]};
            end
            default: begin
                joy_rot = joy_merged;
            end
        endcase
    end

    // output stage, idle level depends on game polarity
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy <= invert_mask;
        end else begin
            game_joy <= joy_rot ^ invert_mask;
        end
    end

endmodule

//--- logic/sys_key_ctrl.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module sys_key_ctrl #(
    parameter bit game_inputs_active_low = 1'b1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   key_reset,
    input  logic                   key_pause,
    input  logic [`GFX_LAYERS-1:0] key_gfx,
    input  logic                   key_service,
    input_evt_if.key_src           evt,
    output logic                   soft_rst,
    output logic [`GFX_LAYERS-1:0] gfx_en,
    output logic                   game_service
);

    logic                   last_reset;
    logic                   last_pause;
    logic [`GFX_LAYERS-1:0] last_gfx;

    // previous key levels
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_reset <= 1'b0;
            last_pause <= 1'b0;
            last_gfx   <= '0;
        end else begin
            last_reset <= key_reset;
            last_pause <= key_pause;
            last_gfx   <= key_gfx;
        end
    end

    // rising edges become single cycle pulses
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst           <= 1'b0;
            evt.key_pause_rise <= 1'b0;
            gfx_en             <= '1;
            game_service       <= game_inputs_active_low;
        end else begin
            soft_rst           <= key_reset & ~last_reset;
            evt.key_pause_rise <= key_pause & ~last_pause;
            // each layer flips on its own key press
            gfx_en             <= gfx_en ^ (key_gfx & ~last_gfx);
            game_service       <= key_service ^ game_inputs_active_low;
        end
    end

endmodule

//--- logic/coin_pause_merge.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module coin_pause_merge
    import board_input_pkg::*;
#(
    parameter bit game_inputs_active_low = 1'b1
) (
    input  logic                      clk_sys,
    input  logic                      rst,
    input_evt_if.merge_dst            evt,
    input  logic [`BOARD_PLAYERS-1:0] key_coin,
    input  logic [`BOARD_PLAYERS-1:0] key_start,
    input  logic                      osd_pause,
    input  logic                      downloading,
    output logic [`BOARD_PLAYERS-1:0] game_coin,
    output logic [`BOARD_PLAYERS-1:0] game_start,
    output logic                      game_pause
);

    localparam logic [`BOARD_PLAYERS-1:0] invert_mask =
        {`BOARD_PLAYERS{game_inputs_active_low}};

    pause_state_e pause_state;
    logic         last_osd_pause;
    logic         last_joy_pause;
    logic         joy_pause;
    logic         pause_toggle;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_coin  <= invert_mask;
            game_start <= invert_mask;
        end else begin
            game_coin  <= (evt.coin_btn | key_coin) ^ invert_mask;
            game_start <= (evt.start_btn | key_start) ^ invert_mask;
        end
    end

    // only players 1 and 2 have a pause button
    assign joy_pause    = evt.pause_btn[0] | evt.pause_btn[1];
    assign pause_toggle = evt.key_pause_rise | (joy_pause & ~last_joy_pause);

    // download clears, then OSD change, then toggle
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pause_state    <= PAUSE_RUN;
            last_osd_pause <= 1'b0;
            last_joy_pause <= 1'b0;
        end else begin
            last_osd_pause <= osd_pause;
            last_joy_pause <= joy_pause;
            if (downloading) begin
                pause_state <= PAUSE_RUN;
            end else if (osd_pause != last_osd_pause) begin
                pause_state <= osd_pause ? PAUSE_HELD : PAUSE_RUN;
            end else if (pause_toggle) begin
                pause_state <= (pause_state == PAUSE_RUN) ? PAUSE_HELD : PAUSE_RUN;
            end
        end
    end

    assign game_pause = (pause_state == PAUSE_HELD);

endmodule

//--- logic/board_input_top.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module board_input_top
    import board_input_pkg::*;
#(
    parameter bit game_inputs_active_low = 1'b1
) (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  board_joy_t                board_joystick1,
    input  board_joy_t                board_joystick2,
    input  board_joy_t                board_joystick3,
    input  board_joy_t                board_joystick4,
    input  game_joy_t                 key_joy1,
    input  game_joy_t                 key_joy2,
    input  game_joy_t                 key_joy3,
    input  logic [`BOARD_PLAYERS-1:0] key_coin,
    input  logic [`BOARD_PLAYERS-1:0] key_start,
    input  logic                      key_reset,
    input  logic                      key_pause,
    input  logic                      key_service,
    input  logic [`GFX_LAYERS-1:0]    key_gfx,
    input  logic                      en4way,
    input  logic                      rot_control,
    input  logic                      flip,
    input  logic                      osd_pause,
    input  logic                      downloading,
    output game_joy_t                 game_joystick1,
    output game_joy_t                 game_joystick2,
    output game_joy_t                 game_joystick3,
    output game_joy_t                 game_joystick4,
    output logic [`BOARD_PLAYERS-1:0] game_coin,
    output logic [`BOARD_PLAYERS-1:0] game_start,
    output logic                      game_service,
    output logic                      game_pause,
    output logic                      soft_rst,
    output logic [`GFX_LAYERS-1:0]    gfx_en
);

    input_evt_if evt ();

    board_joy_t board_joy [`BOARD_PLAYERS];
    game_joy_t  key_joy   [`BOARD_PLAYERS];
    game_joy_t  game_joy  [`BOARD_PLAYERS];

    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    // no keyboard mapping for player 4
    assign key_joy[0] = key_joy1;
    assign key_joy[1] = key_joy2;
    assign key_joy[2] = key_joy3;
    assign key_joy[3] = '0;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    for (genvar i = 0; i < `BOARD_PLAYERS; i++) begin : g_player
        joy_player_path #(
            .player_idx             (i),
            .game_inputs_active_low (game_inputs_active_low)
        ) u_path (
            .clk_sys     (clk_sys),
            .rst         (rst),
            .board_joy   (board_joy[i]),
            .key_joy     (key_joy[i]),
            .en4way      (en4way),
            .rot_control (rot_control),
            .flip        (flip),
            .evt         (evt),
            .game_joy    (game_joy[i])
        );
    end

    sys_key_ctrl #(
        .game_inputs_active_low (game_inputs_active_low)
    ) u_keys (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .key_reset    (key_reset),
        .key_pause    (key_pause),
        .key_gfx      (key_gfx),
        .key_service  (key_service),
        .evt          (evt),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en),
        .game_service (game_service)
    );

    coin_pause_merge #(
        .game_inputs_active_low (game_inputs_active_low)
    ) u_merge (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .evt         (evt),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .osd_pause   (osd_pause),
        .downloading (downloading),
        .game_coin   (game_coin),
        .game_start  (game_start),
        .game_pause  (game_pause)
    );

endmodule

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 16
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(period_ns / 2) clk_sys = ~clk_sys;
    end

    // release on a falling edge, away from the DUT sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk_sys);
        @(negedge clk_sys);
        rst <= 1'b0;
    end

endmodule

//--- verif/board_input_tb.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module board_input_tb
    import board_input_pkg::*;
();

    localparam bit active_low   = 1'b1;
    localparam int reset_cycles = 16;
    localparam int run_limit    = reset_cycles + 2 + 400 + 400 + 300 + 300 + 400 + 100;

    localparam game_joy_t                 joy_mask = {`JOY_OUT_W{active_low}};
    localparam logic [`BOARD_PLAYERS-1:0] pl_mask  = {`BOARD_PLAYERS{active_low}};

    logic clk_sys;
    logic rst;

    board_joy_t                bj [`BOARD_PLAYERS];
    game_joy_t                 kj [`BOARD_PLAYERS];
    logic [`BOARD_PLAYERS-1:0] key_coin;
    logic [`BOARD_PLAYERS-1:0] key_start;
    logic                      key_reset;
    logic                      key_pause;
    logic                      key_service;
    logic [`GFX_LAYERS-1:0]    key_gfx;
    logic                      en4way;
    logic                      rot_control;
    logic                      flip;
    logic                      osd_pause;
    logic                      downloading;

    game_joy_t                 gj [`BOARD_PLAYERS];
    logic [`BOARD_PLAYERS-1:0] game_coin;
    logic [`BOARD_PLAYERS-1:0] game_start;
    logic                      game_service;
    logic                      game_pause;
    logic                      soft_rst;
    logic [`GFX_LAYERS-1:0]    gfx_en;

    // reference model state
    board_joy_t                m_sync [`BOARD_PLAYERS];
    joy_dir_t                  m_mem  [`BOARD_PLAYERS];
    game_joy_t                 m_joy  [`BOARD_PLAYERS];
    logic [`BOARD_PLAYERS-1:0] m_coin;
    logic [`BOARD_PLAYERS-1:0] m_start;
    logic                      m_kp_prev;
    logic                      m_kp_rise;
    logic                      m_jp_prev;
    logic                      m_osd_prev;
    logic                      m_pause;
    logic                      m_kr_prev;
    logic                      m_soft;
    logic [`GFX_LAYERS-1:0]    m_gfx_prev;
    logic [`GFX_LAYERS-1:0]    m_gfx;
    logic                      m_service;

    integer seed;
    int     errors = 0;
    int     checks = 0;
    int     test_errors = 0;
    int     tests_passed = 0;
    int     cycle_count = 0;

    clk_gen #(
        .period_ns    (40),
        .reset_cycles (reset_cycles)
    ) clk_i (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    board_input_top #(
        .game_inputs_active_low (active_low)
    ) dut_i (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (bj[0]),
        .board_joystick2 (bj[1]),
        .board_joystick3 (bj[2]),
        .board_joystick4 (bj[3]),
        .key_joy1        (kj[0]),
        .key_joy2        (kj[1]),
        .key_joy3        (kj[2]),
        .key_coin        (key_coin),
        .key_start       (key_start),
        .key_reset       (key_reset),
        .key_pause       (key_pause),
        .key_service     (key_service),
        .key_gfx         (key_gfx),
        .en4way          (en4way),
        .rot_control     (rot_control),
        .flip            (flip),
        .osd_pause       (osd_pause),
        .downloading     (downloading),
        .game_joystick1  (gj[0]),
        .game_joystick2  (gj[1]),
        .game_joystick3  (gj[2]),
        .game_joystick4  (gj[3]),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .game_pause      (game_pause),
        .soft_rst        (soft_rst),
        .gfx_en          (gfx_en)
    );

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // a single direction wins and a held remembered one keeps priority
    function automatic joy_dir_t filter_4way(input joy_dir_t dirs, input joy_dir_t mem);
        if ($countones(dirs) == 1) begin
            return dirs;
        end
        if ((dirs & mem) != 4'b0) begin
            return mem;
        end
        return 4'b0;
    endfunction

    function automatic board_joy_t sync_word(input int p);
        joy_dir_t dirs;
        dirs = en4way ? filter_4way(bj[p][3:0], m_mem[p]) : bj[p][3:0];
        return {bj[p][`JOY_IN_W-1:`JOY_DIR_W], dirs};
    endfunction

    function automatic game_joy_t rotate_dirs(input game_joy_t w, input logic rot,
                                              input logic flp);
        rot_mode_e mode;
        game_joy_t r;
        r = w;
        if (!rot) begin
            mode = ROT_NONE;
        end else if (flp) begin
            mode = ROT_CW;
        end else begin
            mode = ROT_CCW;
        end
        case (mode)
            // bits are up, down, left, right from 0 to 3
            ROT_CW: begin
                r[0] = w[3];
                r[1] = w[2];
                r[2] = w[0];
                r[3] = w[1];
            end
            ROT_CCW: begin
                r[0] = w[2];
                r[1] = w[3];
                r[2] = w[1];
                r[3] = w[0];
            end
            default: r = w;
        endcase
        return r;
    endfunction

    function automatic logic [`BOARD_PLAYERS-1:0] button_bits(input int pos);
        logic [`BOARD_PLAYERS-1:0] b;
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            b[p] = m_sync[p][pos];
        end
        return b;
    endfunction

    // model registers with an unreset sync stage
    always @(posedge clk_sys) begin
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            m_sync[p] <= sync_word(p);
            if (rst) begin
                m_mem[p] <= 4'b0;
                m_joy[p] <= joy_mask;
            end else begin
                if (en4way) begin
                    m_mem[p] <= filter_4way(bj[p][3:0], m_mem[p]);
                end
                m_joy[p] <= rotate_dirs(m_sync[p][`JOY_OUT_W-1:0] | kj[p],
                                        rot_control, flip) ^ joy_mask;
            end
        end
        if (rst) begin
            m_coin     <= pl_mask;
            m_start    <= pl_mask;
            m_kp_prev  <= 1'b0;
            m_kp_rise  <= 1'b0;
            m_jp_prev  <= 1'b0;
            m_osd_prev <= 1'b0;
            m_pause    <= 1'b0;
            m_kr_prev  <= 1'b0;
            m_soft     <= 1'b0;
            m_gfx_prev <= '0;
            m_gfx      <= '1;
            m_service  <= active_low;
        end else begin
            m_coin     <= (button_bits(`COIN_BIT) | key_coin) ^ pl_mask;
            m_start    <= (button_bits(`START_BIT) | key_start) ^ pl_mask;
            m_kp_prev  <= key_pause;
            m_kp_rise  <= key_pause & ~m_kp_prev;
            m_jp_prev  <= m_sync[0][`PAUSE_BIT] | m_sync[1][`PAUSE_BIT];
            m_osd_prev <= osd_pause;
            if (downloading) begin
                m_pause <= 1'b0;
            end else if (osd_pause != m_osd_prev) begin
                m_pause <= osd_pause;
            end else if (m_kp_rise ||
                         ((m_sync[0][`PAUSE_BIT] | m_sync[1][`PAUSE_BIT]) && !m_jp_prev)) begin
                m_pause <= ~m_pause;
            end
            m_kr_prev  <= key_reset;
            m_soft     <= key_reset & ~m_kr_prev;
            m_gfx_prev <= key_gfx;
            m_gfx      <= m_gfx ^ (key_gfx & ~m_gfx_prev);
            m_service  <= key_service ^ active_low;
        end
    end

    // hard stop in case a wait never returns
    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= run_limit) begin
            $display("timeout: run did not finish within %0d cycles", run_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_outputs();
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            check_val($sformatf("game_joystick%0d", p + 1), 16'(gj[p]), 16'(m_joy[p]));
        end
        check_val("game_coin", 16'(game_coin), 16'(m_coin));
        check_val("game_start", 16'(game_start), 16'(m_start));
        check_val("game_service", 16'(game_service), 16'(m_service));
        check_val("game_pause", 16'(game_pause), 16'(m_pause));
        check_val("soft_rst", 16'(soft_rst), 16'(m_soft));
        check_val("gfx_en", 16'(gfx_en), 16'(m_gfx));
    endtask

    task automatic clear_inputs();
        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            bj[p] = '0;
            kj[p] = '0;
        end
        key_coin    = '0;
        key_start   = '0;
        key_reset   = 1'b0;
        key_pause   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        en4way      = 1'b0;
        rot_control = 1'b0;
        flip        = 1'b0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
    endtask

    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        r = next_rand();
        case (mode)
            2, 3, 4: begin
                for (int p = 0; p < `BOARD_PLAYERS; p++) begin
                    bj[p] = 16'(next_rand());
                    // player 4 has no keyboard mapping
                    if (p < 3 && mode != 4) begin
                        kj[p] = 10'(next_rand());
                    end
                end
                if (mode == 3) begin
                    en4way      = 1'b1;
                    rot_control = r[0];
                    flip        = r[1];
                end
                if (mode == 4) begin
                    key_coin  = r[3:0];
                    key_start = r[7:4];
                end
            end
            5: begin
                key_reset   = r[0];
                key_gfx     = r[4:1] & r[8:5];
                key_service = r[9];
            end
            default: begin
                key_pause = (r[1:0] == 2'd0);
                bj[0][`PAUSE_BIT] = (r[3:2] == 2'd0);
                bj[1][`PAUSE_BIT] = (r[5:4] == 2'd0);
                // rare flips give OSD changes and download windows
                if (r[9:6] == 4'd0) begin
                    osd_pause = ~osd_pause;
                end
                if (r[14:10] == 5'd0) begin
                    downloading = ~downloading;
                end
            end
        endcase
    endtask

    task automatic finish_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (test_errors == 0) ? "pass" : "fail", test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end
        test_errors = 0;
    endtask

    task automatic run_test(input int num, input int cycles, input string name);
        clear_inputs();
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk_sys);
            check_outputs();
            drive_inputs(num);
        end
        finish_test(num, name);
    endtask

    initial begin
        seed = 32'h3b09;
        clear_inputs();
        @(negedge clk_sys);
        while (rst) begin
            @(negedge clk_sys);
        end

        for (int p = 0; p < `BOARD_PLAYERS; p++) begin
            check_val($sformatf("game_joystick%0d", p + 1), 16'(gj[p]), 16'(joy_mask));
        end
        check_val("game_coin", 16'(game_coin), 16'(pl_mask));
        check_val("game_start", 16'(game_start), 16'(pl_mask));
        check_val("game_service", 16'(game_service), 16'(active_low));
        check_val("game_pause", 16'(game_pause), 16'h0);
        check_val("soft_rst", 16'(soft_rst), 16'h0);
        check_val("gfx_en", 16'(gfx_en), 16'hf);
        finish_test(1, "idle levels after reset");

        run_test(2, 400, "joystick passthrough");
        run_test(3, 400, "4-way filter and rotation");
        run_test(4, 300, "coin and start");
        run_test(5, 300, "reset, gfx and service keys");
        run_test(6, 400, "pause control");

        $display("checks %0d, errors %0d, tests passed %0d of 6",
                 checks, errors, tests_passed);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+logic
logic/board_input_pkg.sv
logic/input_evt_if.sv
logic/joy_player_path.sv
logic/sys_key_ctrl.sv
logic/coin_pause_merge.sv
logic/board_input_top.sv
verif/clk_gen.sv
verif/board_input_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run board_input_tb with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module board_input_tb -Mdir obj_dir \
    && ./obj_dir/Vboard_input_tb > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
